/* src/jx2RegPkg.sv */
// JX2 register bank definitions
// register numbering, data word type and the operand port structs
// shared by the general and control register banks

`default_nettype none

package jx2RegPkg;

	localparam int WORD_BITS = 64;
	localparam int NUM_GPR = 32;

	typedef logic [WORD_BITS-1:0] word_t;

	// ids with bit 6 or bit 5 set are never general registers
	typedef enum logic [6:0] {
		REG_R0 = 7'h00,
		REG_R1 = 7'h01,
		REG_R15 = 7'h0F,	// stack pointer
		REG_PC = 7'h20,
		REG_LR = 7'h21,
		REG_SR = 7'h22,
		REG_VBR = 7'h23,
		REG_GBR = 7'h26,
		REG_TBR = 7'h27,
		REG_EXSR = 7'h2B,
		REG_SPC = 7'h30,	// saved pc
		REG_SSP = 7'h33,	// saved sp
		REG_NPC = 7'h3C,
		REG_IMM = 7'h3E,
		REG_ZZR = 7'h3F
	} regId_e;

	typedef struct packed {
		regId_e id;
		word_t value;
	} gprWrite_t;

	typedef struct packed {
		regId_e id;
		word_t value;
	} ctrlWrite_t;

	typedef struct packed {
		logic [32:0] imm;	// sign bit on top
		word_t nextPc;
	} operandIn_t;

endpackage

`default_nettype wire

/* src/jx2CtlPkg.sv */
// JX2 control register definitions
// SR bit layout, trap command encoding, the swap event that
// both banks see, and the control registers exported at the top

`default_nettype none

package jx2CtlPkg;

	import jx2RegPkg::*;

	localparam int SR_RB_BIT = 29;	// register bank select
	localparam int EXC_BITS = 32;

	typedef enum logic [1:0] {
		TRAP_NONE = 2'd0,
		TRAP_ENTER = 2'd1,
		TRAP_RETURN = 2'd2
	} trapKind_e;

	typedef struct packed {
		trapKind_e kind;
		logic [EXC_BITS-1:0] excCode;
	} trapCmd_t;

	// accepted trap, at most one flag set
	typedef struct packed {
		logic enter;
		logic leave;
	} swapEvent_t;

	typedef struct packed {
		word_t pc;
		word_t sr;
		word_t vbr;
		word_t gbr;
	} ctrlView_t;

endpackage

`default_nettype wire

/* src/gprBank.sv */
// General register bank
// 32 x 64b registers, one write port (Ro) and three operand read
// ports (Rm, Rn, Ri) with same-cycle forwarding from Ro.
// Reads can also select the immediate, zero or the next PC.
// R15 is exchanged with SSP on trap entry and return.

`timescale 1ns/10ps
`default_nettype none

module gprBank
	import jx2RegPkg::*, jx2CtlPkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic exHold,
	input regId_e rmId,
	input regId_e rnId,
	input regId_e riId,
	input operandIn_t operand,
	input gprWrite_t gprWr,
	input swapEvent_t swap,
	input word_t savedSp,
	output word_t rmVal,
	output word_t rnVal,
	output word_t riVal,
	output word_t curSp
);

	word_t gprArr [NUM_GPR];
	word_t immExt;
	logic swapNow;

	function automatic logic isGpr(input regId_e id);
		return id[6:5] == 2'b00;
	endfunction

	// one operand port, shared by Rm, Rn and Ri
	function automatic word_t readOperand(input regId_e id);
		word_t val;
		case (id)
			REG_IMM: val = immExt;
			REG_ZZR: val = '0;
			REG_NPC: val = operand.nextPc;
			default: val = isGpr(id) ? gprArr[id[4:0]] : '0;
		endcase
		if (isGpr(id) && id == gprWr.id)
			val = gprWr.value;	// Ro forward, ignores hold
		return val;
	endfunction

	assign immExt = {{(WORD_BITS-33){operand.imm[32]}}, operand.imm};
	assign swapNow = swap.enter | swap.leave;
	assign curSp = gprArr[15];

	always_comb
	begin
		rmVal = readOperand(rmId);
		rnVal = readOperand(rnId);
		riVal = readOperand(riId);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_GPR; i++)
				gprArr[i] <= '0;
		end
		else
		begin
			if (!exHold && isGpr(gprWr.id))
				gprArr[gprWr.id[4:0]] <= gprWr.value;
			// sp exchange wins over an Ro write to R15
			if (swapNow)
				gprArr[15] <= savedSp;
		end
	end

endmodule

`default_nettype wire

/* src/ctrlRegBank.sv */
// Control register bank
// PC, LR, SR, VBR, GBR, TBR plus the saved state SPC, SSP and EXSR.
// One Co write per cycle, Cm read with Co forwarding.
// Trap entry saves PC and SR state and jumps to VBR, return
// restores them. Both exchange SSP with the current R15.

`timescale 1ns/10ps
`default_nettype none

module ctrlRegBank
	import jx2RegPkg::*, jx2CtlPkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic exHold,
	input regId_e cmId,
	input ctrlWrite_t ctrlWr,
	input swapEvent_t swap,
	input wire logic [EXC_BITS-1:0] excCode,
	input word_t curSp,
	output word_t cmVal,
	output word_t savedSp,
	output word_t curSr,
	output ctrlView_t ctrl
);

	localparam word_t RB_MASK = word_t'(1) << SR_RB_BIT;

	word_t pcReg, lrReg, srReg, vbrReg, gbrReg, tbrReg;
	word_t spcReg, sspReg, exsrReg;
	word_t cmBase;
	logic cmKnown;

	always_comb
	begin
		cmKnown = 1'b1;
		case (cmId)
			REG_PC: cmBase = pcReg;
			REG_LR: cmBase = lrReg;
			REG_SR: cmBase = srReg;
			REG_VBR: cmBase = vbrReg;
			REG_GBR: cmBase = gbrReg;
			REG_TBR: cmBase = tbrReg;
			REG_SPC: cmBase = spcReg;
			REG_SSP: cmBase = sspReg;
			REG_EXSR: cmBase = exsrReg;
			default:
			begin
				cmBase = '0;
				cmKnown = 1'b0;
			end
		endcase
		// forward Co only when the id names a real control reg
		cmVal = (cmKnown && ctrlWr.id == cmId) ? ctrlWr.value : cmBase;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pcReg <= '0;
			lrReg <= '0;
			srReg <= '0;
			vbrReg <= '0;
			gbrReg <= '0;
			tbrReg <= '0;
			spcReg <= '0;
			sspReg <= '0;
			exsrReg <= '0;
		end
		else
		begin
			if (!exHold)
			begin
				case (ctrlWr.id)
					REG_PC: pcReg <= ctrlWr.value;
					REG_LR: lrReg <= ctrlWr.value;
					REG_SR: srReg <= ctrlWr.value;
					REG_VBR: vbrReg <= ctrlWr.value;
					REG_GBR: gbrReg <= ctrlWr.value;
					REG_TBR: tbrReg <= ctrlWr.value;
					REG_SPC: spcReg <= ctrlWr.value;
					REG_SSP: sspReg <= ctrlWr.value;
					REG_EXSR: exsrReg <= ctrlWr.value;
					default: ;	// unknown id, no write
				endcase
			end
			// trap state, later assignments override Co
			if (swap.enter)
			begin
				spcReg <= pcReg;
				pcReg <= vbrReg;
				exsrReg <= {srReg[31:0], excCode};
				srReg <= srReg | RB_MASK;
				sspReg <= curSp;
			end
			else if (swap.leave)
			begin
				pcReg <= spcReg;
				srReg <= {srReg[63:32], exsrReg[63:32]};	// RB comes back clear
				spcReg <= spcReg;
				exsrReg <= exsrReg;
				sspReg <= curSp;
			end
		end
	end

	assign savedSp = sspReg;
	assign curSr = srReg;
	assign ctrl = '{pc: pcReg, sr: srReg, vbr: vbrReg, gbr: gbrReg};

endmodule

`default_nettype wire

/* src/trapSequencer.sv */
// Trap sequencer
// accepts enter only with SR.RB clear and return only with SR.RB
// set, then blocks the following cycle while SR settles.
// Drives one swap event to both register banks.

`timescale 1ns/10ps
`default_nettype none

module trapSequencer
	import jx2RegPkg::*, jx2CtlPkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input trapCmd_t trap,
	input word_t curSr,
	output swapEvent_t swap,
	output logic [EXC_BITS-1:0] excCode
);

	logic pending;	// a trap was accepted last cycle
	logic bankB;

	assign bankB = curSr[SR_RB_BIT];

	always_comb
	begin
		swap.enter = !pending && !bankB && trap.kind == TRAP_ENTER;
		swap.leave = !pending && bankB && trap.kind == TRAP_RETURN;
		excCode = swap.enter ? trap.excCode : '0;	// only meaningful on entry
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			pending <= 1'b0;
		else
			pending <= swap.enter | swap.leave;
	end

endmodule

`default_nettype wire

/* src/regFileTop.sv */
// JX2 register file top
// general bank, control bank and the trap sequencer that
// swaps state between them on exception entry and return

`timescale 1ns/10ps
`default_nettype none

module regFileTop
	import jx2RegPkg::*, jx2CtlPkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input regId_e rmId,
	input regId_e rnId,
	input regId_e riId,
	input operandIn_t operand,
	input gprWrite_t gprWr,
	input regId_e cmId,
	input ctrlWrite_t ctrlWr,
	input trapCmd_t trap,
	input wire logic exHold,
	output word_t rmVal,
	output word_t rnVal,
	output word_t riVal,
	output word_t cmVal,
	output ctrlView_t ctrl
);

	swapEvent_t swap;
	logic [EXC_BITS-1:0] excCode;
	word_t curSr;
	word_t curSp;	// R15 into the bank
	word_t savedSp;	// SSP back to R15

	gprBank gprs (
		.clock(clock),
		.reset(reset),
		.exHold(exHold),
		.rmId(rmId),
		.rnId(rnId),
		.riId(riId),
		.operand(operand),
		.gprWr(gprWr),
		.swap(swap),
		.savedSp(savedSp),
		.rmVal(rmVal),
		.rnVal(rnVal),
		.riVal(riVal),
		.curSp(curSp)
	);

	ctrlRegBank ctrls (
		.clock(clock),
		.reset(reset),
		.exHold(exHold),
		.cmId(cmId),
		.ctrlWr(ctrlWr),
		.swap(swap),
		.excCode(excCode),
		.curSp(curSp),
		.cmVal(cmVal),
		.savedSp(savedSp),
		.curSr(curSr),
		.ctrl(ctrl)
	);

	trapSequencer seq (
		.clock(clock),
		.reset(reset),
		.trap(trap),
		.curSr(curSr),
		.swap(swap),
		.excCode(excCode)
	);

endmodule

`default_nettype wire

/* tests/regFileChecker.sv */
// Register file checker
// keeps a model of the general and control banks plus the trap
// sequencer, updates it on each rising edge and compares every
// read output and the control view on the falling edge

`timescale 1ns/10ps
`default_nettype none

module regFileChecker
	import jx2RegPkg::*, jx2CtlPkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire regId_e rmId,
	input wire regId_e rnId,
	input wire regId_e riId,
	input wire operandIn_t operand,
	input wire gprWrite_t gprWr,
	input wire regId_e cmId,
	input wire ctrlWrite_t ctrlWr,
	input wire trapCmd_t trap,
	input wire logic exHold,
	input wire word_t rmVal,
	input wire word_t rnVal,
	input wire word_t riVal,
	input wire word_t cmVal,
	input wire ctrlView_t ctrl,
	output int errors
);

	word_t gpr [NUM_GPR];
	word_t pc, lr, sr, vbr, gbr, tbr, spc, ssp, exsr;
	logic pending;	// trap taken last cycle
	int errCount = 0;

	assign errors = errCount;

	function automatic word_t expOperand(input regId_e id);
		word_t v;
		if (id[6:5] == 2'b00)
			v = (id == gprWr.id) ? gprWr.value : gpr[id[4:0]];
		else if (id == REG_IMM)
			v = {{31{operand.imm[32]}}, operand.imm};
		else if (id == REG_NPC)
			v = operand.nextPc;
		else
			v = '0;	// ZZR and anything unknown
		return v;
	endfunction

	function automatic word_t expCtrl(input regId_e id);
		word_t v;
		logic known;
		known = 1'b1;
		case (id)
			REG_PC: v = pc;
			REG_LR: v = lr;
			REG_SR: v = sr;
			REG_VBR: v = vbr;
			REG_GBR: v = gbr;
			REG_TBR: v = tbr;
			REG_SPC: v = spc;
			REG_SSP: v = ssp;
			REG_EXSR: v = exsr;
			default:
			begin
				v = '0;
				known = 1'b0;
			end
		endcase
		if (known && ctrlWr.id == id)
			v = ctrlWr.value;
		return v;
	endfunction

	task automatic compare(input string what, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			errCount++;
			$display("mismatch at %0t: %s is %h, model expects %h", $time, what, got, exp);
		end
	endtask

	task automatic stepModel();
		logic enter, leave;
		word_t oldSp, oldSsp, oldPc, oldSr, oldVbr, oldSpc, oldExsr;
		enter = !pending && !sr[SR_RB_BIT] && trap.kind == TRAP_ENTER;
		leave = !pending && sr[SR_RB_BIT] && trap.kind == TRAP_RETURN;
		oldSp = gpr[15];
		oldSsp = ssp;
		oldPc = pc;
		oldSr = sr;
		oldVbr = vbr;
		oldSpc = spc;
		oldExsr = exsr;
		if (!exHold)
		begin
			if (gprWr.id[6:5] == 2'b00)
				gpr[gprWr.id[4:0]] = gprWr.value;
			case (ctrlWr.id)
				REG_PC: pc = ctrlWr.value;
				REG_LR: lr = ctrlWr.value;
				REG_SR: sr = ctrlWr.value;
				REG_VBR: vbr = ctrlWr.value;
				REG_GBR: gbr = ctrlWr.value;
				REG_TBR: tbr = ctrlWr.value;
				REG_SPC: spc = ctrlWr.value;
				REG_SSP: ssp = ctrlWr.value;
				REG_EXSR: exsr = ctrlWr.value;
				default: ;
			endcase
		end
		if (enter)
		begin
			spc = oldPc;
			pc = oldVbr;	// jump to the vector base
			exsr = {oldSr[31:0], trap.excCode};
			sr = oldSr | (word_t'(1) << SR_RB_BIT);
		end
		else if (leave)
		begin
			pc = oldSpc;
			sr = {oldSr[63:32], oldExsr[63:32]};
			spc = oldSpc;
			exsr = oldExsr;
		end
		if (enter || leave)
		begin
			ssp = oldSp;	// stack pointers trade places
			gpr[15] = oldSsp;
		end
		pending = enter || leave;
	endtask

	always @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_GPR; i++)
				gpr[i] = '0;
			{pc, lr, sr, vbr, gbr, tbr, spc, ssp, exsr} = '0;
			pending = 1'b0;
		end
		else
			stepModel();
	end

	always @(negedge clock)
	begin
		if (!reset)
		begin
			compare("rmVal", rmVal, expOperand(rmId));
			compare("rnVal", rnVal, expOperand(rnId));
			compare("riVal", riVal, expOperand(riId));
			compare("cmVal", cmVal, expCtrl(cmId));
			compare("ctrl.pc", ctrl.pc, pc);
			compare("ctrl.sr", ctrl.sr, sr);
			compare("ctrl.vbr", ctrl.vbr, vbr);
			compare("ctrl.gbr", ctrl.gbr, gbr);
		end
	end

endmodule

`default_nettype wire

/* tests/regFileTb.sv */
// Register file testbench
// clock, reset and seeded random stimulus for five tests,
// a cycle limit and the closing report

`timescale 1ns/10ps
`default_nettype none

module regFileTb
	import jx2RegPkg::*, jx2CtlPkg::*;
;

	localparam int RESET_CYCLES = 10;
	localparam int LONG_TEST = 400;	// tests 1 to 3
	localparam int SHORT_TEST = 200;	// tests 4 and 5
	localparam int TIMEOUT_CYCLES = 3 * LONG_TEST + 2 * SHORT_TEST + RESET_CYCLES + 50;

	logic clock, reset, exHold;
	regId_e rmId, rnId, riId, cmId;
	operandIn_t operand;
	gprWrite_t gprWr;
	ctrlWrite_t ctrlWr;
	trapCmd_t trap;
	word_t rmVal, rnVal, riVal, cmVal;
	ctrlView_t ctrl;
	int checkErrors;
	int passCount = 0;
	int failCount = 0;
	int cycleCount = 0;
	integer seed;

	regFileTop DUT (
		.clock(clock), .reset(reset),
		.rmId(rmId), .rnId(rnId), .riId(riId),
		.operand(operand), .gprWr(gprWr), .cmId(cmId),
		.ctrlWr(ctrlWr), .trap(trap), .exHold(exHold),
		.rmVal(rmVal), .rnVal(rnVal), .riVal(riVal),
		.cmVal(cmVal), .ctrl(ctrl)
	);

	regFileChecker modelCheck (
		.clock(clock), .reset(reset),
		.rmId(rmId), .rnId(rnId), .riId(riId),
		.operand(operand), .gprWr(gprWr), .cmId(cmId),
		.ctrlWr(ctrlWr), .trap(trap), .exHold(exHold),
		.rmVal(rmVal), .rnVal(rnVal), .riVal(riVal),
		.cmVal(cmVal), .ctrl(ctrl), .errors(checkErrors)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic regId_e toGprId(input logic [4:0] n);
		return regId_e'({2'b00, n});
	endfunction

	// mostly control regs with SR kept rare so the bank bit moves slowly
	function automatic regId_e pickCtrlId(input logic [3:0] sel);
		regId_e id;
		case (sel)
			4'd0, 4'd9: id = REG_PC;
			4'd1, 4'd10: id = REG_LR;
			4'd2: id = REG_SR;
			4'd3, 4'd11: id = REG_VBR;
			4'd4, 4'd12: id = REG_GBR;
			4'd5, 4'd13: id = REG_TBR;
			4'd6: id = REG_SPC;
			4'd7: id = REG_SSP;
			4'd8: id = REG_EXSR;
			4'd14: id = REG_R1;	// not a control reg
			default: id = REG_ZZR;
		endcase
		return id;
	endfunction

	function automatic regId_e pickSpecialId(input logic [1:0] sel, input regId_e wrId);
		regId_e id;
		case (sel)
			2'd0: id = wrId;
			2'd1: id = REG_IMM;
			2'd2: id = REG_ZZR;
			default: id = REG_NPC;
		endcase
		return id;
	endfunction

	task automatic driveCycle(input int mode);
		logic [31:0] r;
		@(posedge clock);
		#1;
		r = $random(seed);
		exHold = (mode == 2 || mode >= 4) ? r[0] : 1'b0;
		gprWr.id = (mode == 5 && r[1]) ? REG_R15 : toGprId(r[6:2]);
		if (mode == 2 && r[9:7] == 3'd0)
			gprWr.id = REG_NPC;	// non-general id that the bank drops
		gprWr.value = {$random(seed), $random(seed)};
		operand.imm = {r[10], $random(seed)};
		operand.nextPc = {$random(seed), $random(seed)};
		rmId = toGprId(r[15:11]);
		rnId = toGprId(r[20:16]);
		riId = (mode == 5) ? REG_R15 : toGprId(r[25:21]);
		if (mode == 2)
		begin
			rmId = pickSpecialId(r[27:26], gprWr.id);
			rnId = gprWr.id;
		end
		r = $random(seed);
		ctrlWr.id = (mode <= 2) ? REG_ZZR : pickCtrlId(r[3:0]);
		ctrlWr.value = {$random(seed), $random(seed)};
		cmId = (mode == 3 && r[4]) ? ctrlWr.id : pickCtrlId(r[8:5]);
		trap.kind = TRAP_NONE;
		if (mode == 5 && r[9])
			trap.kind = r[10] ? TRAP_RETURN : TRAP_ENTER;
		trap.excCode = $random(seed);
	endtask

	task automatic runTest(input int num, input string name, input int cycles);
		int errorsBefore;
		errorsBefore = checkErrors;
		repeat (cycles)
			driveCycle(num);
		@(negedge clock);
		#1;	// past the last compare
		if (checkErrors == errorsBefore)
		begin
			passCount++;
			$display("test %0d %s: passed after %0d cycles", num, name, cycles);
		end
		else
		begin
			failCount++;
			$display("test %0d %s: failed with %0d mismatches", num, name,
				checkErrors - errorsBefore);
		end
	endtask

	initial
	begin
		while (cycleCount < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		seed = 32'hb582d48a;
		reset = 1'b1;
		exHold = 1'b0;
		rmId = REG_R0;
		rnId = REG_R0;
		riId = REG_R0;
		cmId = REG_PC;
		operand = '0;
		gprWr = '0;
		ctrlWr = '0;	// id R0 is no control register
		trap = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		runTest(1, "gpr write and read", LONG_TEST);
		runTest(2, "forwarding and special ids", LONG_TEST);
		runTest(3, "control registers", LONG_TEST);
		runTest(4, "hold", SHORT_TEST);
		runTest(5, "traps", SHORT_TEST);
		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0 && checkErrors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
src/jx2RegPkg.sv
src/jx2CtlPkg.sv
src/gprBank.sv
src/ctrlRegBank.sv
src/trapSequencer.sv
src/regFileTop.sv
tests/regFileChecker.sv
tests/regFileTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the register file testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f build.f --top-module regFileTb -o regFileSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/regFileSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi
exit 0
